/* tb/keccak_vectors.txt */
// Columns: opcode, lane address, data word; run records add 25 expected lanes, lane 0 first
// Opcodes: 1 absorb, 2 clear, 3 run and check, 4 run with busy pokes, 5 absorb with clear, 0 end

// Permute the zero state
3 00 0000000000000000
F1258F7940E1DDE7 84D5CCF933C0478A D598261EA65AA9EE BD1547306F80494D 8B284E056253D057
FF97A42D7F8E6FD4 90FEE5A0A44647C4 8C5BDA0CD6192E76 AD30A6F71B19059C 30935AB7D08FFC64
EB5AA93F2317D635 A9A6E6260D712103 81A57C16DBCF555F 43B831CD0347C826 01F22F1A11A5569F
05E5635A21D9AE61 64BEFEF28CC970F2 613670957BC46611 B87C5A554FD00ECB 8C3EE88A1CCF32C8
940C7922AE3A2614 1841F924A2C509E4 16F53526E70465C2 75F644E97F30A13B EAF1FF7B5CECA249

// Chained second run with commands poked while busy
4 00 0000000000000000
2D5C954DF96ECB3C 6A332CD07057B56D 093D8D1270D76B6C 8A20D9B25569D094 4F9C4F99E5E7F156
F957B9A2DA65FB38 85773DAE1275AF0D FAF4F247C3D810F7 1F1B9EE6F79A8759 E4FECC0FEE98B425
68CE61B6B9CE68A1 DEEA66C4BA8F974F 33C43D836EAFB1F5 E00654042719DBD9 7CF8A9F009831265
FD5449A6BF174743 97DDAD33D8994B40 48EAD5FC5D0BE774 E3B8C8EE55B7B03C 91A0226E649E42E9
900E3129E7BADD7B 202A9EC5FAA3CCE8 5B3402464E1C3DB6 609F4E62A44C1059 20D06CD26A8FBF5C

// Rebuild the first digest by absorbing, lane 3 in two words
2 00 0000000000000000
1 03 FFFFFFFFFFFFFFFF
1 18 EAF1FF7B5CECA249
1 17 75F644E97F30A13B
1 16 16F53526E70465C2
1 15 1841F924A2C509E4
1 14 940C7922AE3A2614
1 13 8C3EE88A1CCF32C8
1 12 B87C5A554FD00ECB
1 11 613670957BC46611
1 10 64BEFEF28CC970F2
1 0f 05E5635A21D9AE61
1 0e 01F22F1A11A5569F
1 0d 43B831CD0347C826
1 0c 81A57C16DBCF555F
1 0b A9A6E6260D712103
1 0a EB5AA93F2317D635
1 09 30935AB7D08FFC64
1 08 AD30A6F71B19059C
1 07 8C5BDA0CD6192E76
1 06 90FEE5A0A44647C4
1 05 FF97A42D7F8E6FD4
1 04 8B284E056253D057
1 03 42EAB8CF907FB6B2
1 02 D598261EA65AA9EE
1 01 84D5CCF933C0478A
1 00 F1258F7940E1DDE7

// Absorbed state permutes to the second digest
3 00 0000000000000000
2D5C954DF96ECB3C 6A332CD07057B56D 093D8D1270D76B6C 8A20D9B25569D094 4F9C4F99E5E7F156
F957B9A2DA65FB38 85773DAE1275AF0D FAF4F247C3D810F7 1F1B9EE6F79A8759 E4FECC0FEE98B425
68CE61B6B9CE68A1 DEEA66C4BA8F974F 33C43D836EAFB1F5 E00654042719DBD9 7CF8A9F009831265
FD5449A6BF174743 97DDAD33D8994B40 48EAD5FC5D0BE774 E3B8C8EE55B7B03C 91A0226E649E42E9
900E3129E7BADD7B 202A9EC5FAA3CCE8 5B3402464E1C3DB6 609F4E62A44C1059 20D06CD26A8FBF5C

// Absorb wins over clear, then a plain clear
5 07 0123456789ABCDEF
2 00 0000000000000000
0 00 0000000000000000

/* all.f */
rtl/keccak_pkg.sv
rtl/keccak_ctrl.sv
rtl/keccak_state.sv
rtl/keccak_round_logic.sv
rtl/keccak_round_top.sv
tb/tb_keccak_round.sv

/* Makefile */
# Verilator flow for the Keccak round engine

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_keccak_round
RTL_TOP    ?= keccak_round_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS ?= rtl/keccak_pkg.sv rtl/keccak_ctrl.sv rtl/keccak_state.sv \
            rtl/keccak_round_logic.sv rtl/keccak_round_top.sv
TB_SRCS  ?= tb/tb_keccak_round.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the log holds the pass message
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_keccak_round.sv */
`default_nettype none

module tb_keccak_round;

  localparam int Width     = 1600;
  localparam int LaneW     = 64;
  localparam int NumLanes  = 25;
  localparam int NumRounds = 24;
  localparam int MemDepth  = 1024;

  // Every record starts with opcode, lane address and data word
  localparam int HeadWords = 3;
  localparam int RunWords  = HeadWords + NumLanes;

  localparam logic [63:0] OpEnd       = 64'h0;
  localparam logic [63:0] OpAbsorb    = 64'h1;
  localparam logic [63:0] OpClear     = 64'h2;
  localparam logic [63:0] OpRun       = 64'h3;
  localparam logic [63:0] OpBusyPoke  = 64'h4;
  localparam logic [63:0] OpAbsorbClr = 64'h5;

  logic                   clk_i;
  logic                   rst_n;
  logic                   valid_i;
  keccak_pkg::lane_addr_t addr_i;
  keccak_pkg::din_t       data_i;
  logic                   ready_o;
  logic                   run_i;
  logic                   clear_i;
  logic                   complete_o;
  logic [Width-1:0]       state_o;

  // Vector file image and the expected state
  logic [63:0]      vec_mem [MemDepth];
  logic [Width-1:0] model_state;

  int     errors;
  int     checks;
  int     cycle_cnt;
  int     num_records;
  int     watchdog_cycles;
  integer seed;

  keccak_round_top #(
    .Width     (Width),
    .NumRounds (NumRounds)
  ) uut (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .ready_o    (ready_o),
    .run_i      (run_i),
    .clear_i    (clear_i),
    .complete_o (complete_o),
    .state_o    (state_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Words taken by the record that starts with this opcode
  function automatic int record_words(input logic [63:0] op);
    if (op == OpRun || op == OpBusyPoke) begin
      return RunWords;
    end
    return HeadWords;
  endfunction

  // Lowest lane that differs, -1 when all lanes agree
  function automatic int first_bad_lane(input logic [Width-1:0] got,
                                        input logic [Width-1:0] exp);
    int idx;
    idx = -1;
    for (int i = NumLanes - 1; i >= 0; i--) begin
      if (got[i*LaneW +: LaneW] !== exp[i*LaneW +: LaneW]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic check_state(input string what);
    int lane;
    lane = first_bad_lane(state_o, model_state);
    checks++;
    assert (lane < 0) else begin
      $display("Fail at %0t: %s, lane %0d is %h, expected %h", $time, what, lane,
               state_o[lane*LaneW +: LaneW], model_state[lane*LaneW +: LaneW]);
      errors++;
    end
  endtask

  // One word into one lane, expected state is the running XOR
  task automatic absorb_word(input keccak_pkg::lane_addr_t addr, input keccak_pkg::din_t data,
                             input logic with_clear, input string what);
    int waited;
    waited = 0;
    @(posedge clk_i);
    valid_i <= 1'b1;
    addr_i  <= addr;
    data_i  <= data;
    clear_i <= with_clear;
    // Source holds valid until ready
    @(negedge clk_i);
    while (ready_o !== 1'b1 && waited < 2 * NumRounds) begin
      @(negedge clk_i);
      waited++;
    end
    if (ready_o !== 1'b1) begin
      $display("Absorb into lane %0d was never accepted, ready_o stayed low", addr);
      errors++;
    end
    // Handshake edge
    @(posedge clk_i);
    valid_i <= 1'b0;
    clear_i <= 1'b0;
    model_state[int'(addr)*LaneW +: LaneW] = model_state[int'(addr)*LaneW +: LaneW] ^ data;
    @(negedge clk_i);
    check_state(what);
  endtask

  task automatic clear_state();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    model_state = '0;
    @(negedge clk_i);
    check_state("clear");
  endtask

  // Run pulse, then wait for complete_o with a cycle limit
  task automatic run_and_check(input int base, input logic poke);
    int               cycles;
    logic             done;
    logic [Width-1:0] expected;
    integer           rnd;
    for (int i = 0; i < NumLanes; i++) begin
      expected[i*LaneW +: LaneW] = vec_mem[base + HeadWords + i];
    end
    cycles = 0;
    done   = 1'b0;
    @(posedge clk_i);
    run_i <= 1'b1;
    // Run sampled on this edge
    @(posedge clk_i);
    run_i <= 1'b0;
    while (!done && cycles <= 2 * NumRounds) begin
      @(negedge clk_i);
      if (complete_o === 1'b1) begin
        done = 1'b1;
      end else begin
        checks++;
        assert (ready_o === 1'b0) else begin
          $display("Fail at %0t: ready_o high %0d cycles after the run edge", $time, cycles);
          errors++;
        end
        @(posedge clk_i);
        cycles++;
        // Commands while busy, all must be dropped
        if (poke) begin
          rnd = $random(seed);
          valid_i <= (cycles == 3 || cycles == 20);
          clear_i <= (cycles == 8);
          run_i   <= (cycles == 12);
          addr_i  <= rnd[4:0];
          data_i  <= {rnd, ~rnd};
        end
      end
    end
    if (!done) begin
      $display("complete_o never rose after the run of record at word %0d", base);
      errors++;
    end else begin
      checks++;
      assert (cycles == NumRounds) else begin
        $display("Fail at %0t: complete_o after %0d cycles, expected %0d",
                 $time, cycles, NumRounds);
        errors++;
      end
      checks++;
      assert (ready_o === 1'b1) else begin
        $display("Fail at %0t: ready_o low together with complete_o", $time);
        errors++;
      end
      model_state = expected;
      check_state("digest");
      // Pulse is one cycle wide
      @(posedge clk_i);
      @(negedge clk_i);
      checks++;
      assert (complete_o === 1'b0) else begin
        $display("Fail at %0t: complete_o high for more than one cycle", $time);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int          p;
    logic [63:0] op;
    clk_i       = 1'b0;
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    addr_i      = '0;
    data_i      = '0;
    run_i       = 1'b0;
    clear_i     = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    num_records = 0;
    seed        = 32'h27ed;
    model_state = '0;
    for (int i = 0; i < MemDepth; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("tb/keccak_vectors.txt", vec_mem);

    // Count records to size the watchdog
    p = 0;
    while (p < MemDepth && vec_mem[p] != OpEnd) begin
      num_records++;
      p += record_words(vec_mem[p]);
    end
    if (num_records == 0) begin
      $display("The vector file holds no records");
      errors++;
    end
    watchdog_cycles = num_records * 40 + 100;

    repeat (4) @(posedge clk_i);
    rst_n <= 1'b1;

    // Idle and zero out of reset
    @(negedge clk_i);
    checks++;
    assert (ready_o === 1'b1 && complete_o === 1'b0) else begin
      $display("Fail at %0t: after reset ready_o %b complete_o %b", $time, ready_o, complete_o);
      errors++;
    end
    check_state("reset");

    p = 0;
    while (p < MemDepth && vec_mem[p] != OpEnd) begin
      op = vec_mem[p];
      case (op)
        OpAbsorb: begin
          absorb_word(keccak_pkg::lane_addr_t'(vec_mem[p+1]), vec_mem[p+2], 1'b0, "absorb");
        end
        OpAbsorbClr: begin
          absorb_word(keccak_pkg::lane_addr_t'(vec_mem[p+1]), vec_mem[p+2], 1'b1,
                      "absorb with clear");
        end
        OpClear: begin
          clear_state();
        end
        OpRun: begin
          run_and_check(p, 1'b0);
        end
        OpBusyPoke: begin
          run_and_check(p, 1'b1);
        end
        default: begin
          $display("Unknown opcode %h in the vector file at word %0d", op, p);
          errors++;
        end
      endcase
      p += record_words(op);
    end

    repeat (2) @(posedge clk_i);
    $display("Errors: %0d of %0d checks in %0d cycles", errors, checks, cycle_cnt);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/keccak_round_top.sv */
`default_nettype none

module keccak_round_top #(
  parameter int Width     = keccak_pkg::StateWidth,
  parameter int NumRounds = keccak_pkg::NumRounds
) (
  input  logic                   clk_i,
  input  logic                   rst_n,

  // Absorb port, taken on valid_i and ready_o
  input  logic                   valid_i,
  input  keccak_pkg::lane_addr_t addr_i,
  input  keccak_pkg::din_t       data_i,
  output logic                   ready_o,

  // Run is a pulse, clear zeroes the state
  input  logic                   run_i,
  input  logic                   clear_i,

  output logic                   complete_o,
  output logic [Width-1:0]       state_o
);

  // FSM to storage controls
  logic                   xor_msg;
  logic                   clr_state;
  logic                   update_state;
  keccak_pkg::round_idx_t round;

  // Round logic result back into storage
  logic [Width-1:0]       next_state;

  keccak_ctrl #(
    .NumRounds (NumRounds)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .clear_i        (clear_i),
    .run_i          (run_i),
    .ready_o        (ready_o),
    .xor_msg_o      (xor_msg),
    .clr_state_o    (clr_state),
    .update_state_o (update_state),
    .round_o        (round),
    .complete_o     (complete_o)
  );

  // Stored state feeds both the round logic and the output
  keccak_state #(
    .Width (Width)
  ) u_state (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .xor_msg_i      (xor_msg),
    .clr_state_i    (clr_state),
    .update_state_i (update_state),
    .addr_i         (addr_i),
    .data_i         (data_i),
    .next_i         (next_state),
    .state_o        (state_o)
  );

  keccak_round_logic #(
    .Width (Width)
  ) u_round_logic (
    .state_i (state_o),
    .round_i (round),
    .state_o (next_state)
  );

endmodule

`default_nettype wire

/* rtl/keccak_round_logic.sv */
`default_nettype none

module keccak_round_logic #(
  parameter int Width = keccak_pkg::StateWidth
) (
  input  logic [Width-1:0]       state_i,
  input  keccak_pkg::round_idx_t round_i,
  output logic [Width-1:0]       state_o
);

  localparam int LaneW = Width / keccak_pkg::NumLanes;

  typedef logic [LaneW-1:0] lane_t;

  // Lane views of each step, index x + 5*y
  lane_t lane_in   [keccak_pkg::NumLanes];
  lane_t theta_out [keccak_pkg::NumLanes];
  lane_t rho_out   [keccak_pkg::NumLanes];
  lane_t pi_out    [keccak_pkg::NumLanes];
  lane_t chi_out   [keccak_pkg::NumLanes];

  // Column parities and their Theta mix
  lane_t col_par [5];
  lane_t col_mix [5];

  // Iota constant cut to the lane width
  lane_t round_const;

  // Left rotation, offset taken modulo the lane width
  function automatic lane_t rotl(input lane_t v, input int n);
    logic [2*LaneW-1:0] dbl;
    dbl = {v, v} << (n % LaneW);
    return dbl[2*LaneW-1 -: LaneW];
  endfunction

  always_comb begin
    for (int i = 0; i < keccak_pkg::NumLanes; i++) begin
      lane_in[i] = state_i[i*LaneW +: LaneW];
    end
  end

  //////////////////////////////////////////////////
  // Theta
  //////////////////////////////////////////////////

  always_comb begin
    for (int x = 0; x < 5; x++) begin
      col_par[x] = lane_in[x] ^ lane_in[x+5] ^ lane_in[x+10] ^ lane_in[x+15] ^ lane_in[x+20];
    end
    // Left neighbour parity plus rotated right neighbour parity
    for (int x = 0; x < 5; x++) begin
      col_mix[x] = col_par[(x+4)%5] ^ rotl(col_par[(x+1)%5], 1);
    end
    for (int i = 0; i < keccak_pkg::NumLanes; i++) begin
      theta_out[i] = lane_in[i] ^ col_mix[i%5];
    end
  end

  //////////////////////////////////////////////////
  // Rho
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < keccak_pkg::NumLanes; i++) begin
      rho_out[i] = rotl(theta_out[i], keccak_pkg::RhoOffset[i]);
    end
  end

  //////////////////////////////////////////////////
  // Pi
  //////////////////////////////////////////////////

  // Lane (x, y) moves to (y, 2x + 3y)
  always_comb begin
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        pi_out[y + 5*((2*x + 3*y) % 5)] = rho_out[x + 5*y];
      end
    end
  end

  //////////////////////////////////////////////////
  // Chi
  //////////////////////////////////////////////////

  // Nonlinear mix along each row
  always_comb begin
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        chi_out[x + 5*y] = pi_out[x + 5*y]
                         ^ (~pi_out[(x+1)%5 + 5*y] & pi_out[(x+2)%5 + 5*y]);
      end
    end
  end

  //////////////////////////////////////////////////
  // Iota
  //////////////////////////////////////////////////

  assign round_const = keccak_pkg::RoundConst[round_i][LaneW-1:0];

  // Constant goes into lane 0 only
  always_comb begin
    for (int i = 0; i < keccak_pkg::NumLanes; i++) begin
      state_o[i*LaneW +: LaneW] = chi_out[i];
    end
    state_o[LaneW-1:0] = chi_out[0] ^ round_const;
  end

endmodule

`default_nettype wire

/* rtl/keccak_state.sv */
`default_nettype none

module keccak_state #(
  parameter int Width = keccak_pkg::StateWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_n,

  // Controls from the FSM
  input  logic                   xor_msg_i,
  input  logic                   clr_state_i,
  input  logic                   update_state_i,

  // Absorb word and its lane
  input  keccak_pkg::lane_addr_t addr_i,
  input  keccak_pkg::din_t       data_i,

  // Result of one round
  input  logic [Width-1:0]       next_i,

  output logic [Width-1:0]       state_o
);

  localparam int LaneW = Width / keccak_pkg::NumLanes;

  logic [Width-1:0] state_q;
  logic [Width-1:0] state_d;

  // Current state with the message word folded into one lane
  logic [Width-1:0] absorb_state;

  always_comb begin
    absorb_state = state_q;
    for (int i = 0; i < keccak_pkg::NumLanes; i++) begin
      if (addr_i == keccak_pkg::lane_addr_t'(i)) begin
        absorb_state[i*LaneW +: LaneW] = state_q[i*LaneW +: LaneW] ^ data_i[LaneW-1:0];
      end
    end
  end

  // Absorb and round share the same write path
  assign state_d = xor_msg_i ? absorb_state : next_i;

  // Clear has priority over any update
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '0;
    end else if (clr_state_i) begin
      state_q <= '0;
    end else if (update_state_i) begin
      state_q <= state_d;
    end
  end

  // Also the digest once the permutation is done
  assign state_o = state_q;

endmodule

`default_nettype wire

/* rtl/keccak_ctrl.sv */
`default_nettype none

module keccak_ctrl #(
  parameter int NumRounds = keccak_pkg::NumRounds
) (
  input  logic                   clk_i,
  input  logic                   rst_n,

  // Commands, only taken while idle
  input  logic                   valid_i,
  input  logic                   clear_i,
  input  logic                   run_i,

  // Idle indication doubles as absorb ready
  output logic                   ready_o,

  // Controls towards the state register
  output logic                   xor_msg_o,
  output logic                   clr_state_o,
  output logic                   update_state_o,
  output keccak_pkg::round_idx_t round_o,

  // One-cycle pulse after the last round
  output logic                   complete_o
);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  // Unmasked engine needs only two states
  typedef enum logic {
    st_idle,
    st_active
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Round counter controls
  logic inc_round;
  logic rst_round;
  logic last_round;

  // Completion before its output register
  logic complete_d;

  assign last_round = (round_o == keccak_pkg::round_idx_t'(NumRounds - 1));

  always_comb begin
    state_d        = state_q;
    xor_msg_o      = 1'b0;
    clr_state_o    = 1'b0;
    update_state_o = 1'b0;
    inc_round      = 1'b0;
    rst_round      = 1'b0;
    complete_d     = 1'b0;

    case (state_q)
      st_idle: begin
        // Absorb wins over clear, clear wins over run
        if (valid_i) begin
          xor_msg_o      = 1'b1;
          update_state_o = 1'b1;
        end else if (clear_i) begin
          clr_state_o = 1'b1;
        end else if (run_i) begin
          state_d = st_active;
        end
      end

      st_active: begin
        // One full round lands in the state every cycle
        update_state_o = 1'b1;
        if (last_round) begin
          state_d    = st_idle;
          rst_round  = 1'b1;
          complete_d = 1'b1;
        end else begin
          inc_round = 1'b1;
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // Commands are blocked while rounds run
  assign ready_o = (state_q == st_idle);

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Round number, 0 while idle
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      round_o <= '0;
    end else if (rst_round) begin
      round_o <= '0;
    end else if (inc_round) begin
      round_o <= round_o + 1'b1;
    end
  end

  // Pulse lines up with the final state on state_o
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      complete_o <= 1'b0;
    end else begin
      complete_o <= complete_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/keccak_pkg.sv */
`default_nettype none

package keccak_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Permutation width of Keccak-f[1600]
  parameter int StateWidth = 1600;

  // The state is a 5 x 5 array of lanes, lane index is x + 5*y
  parameter int NumLanes = 25;
  parameter int LaneWidth = StateWidth / NumLanes;

  // One message word per absorb handshake
  parameter int DinWidth = 64;

  // Keccak-f runs 12 + 2*l rounds, l = log2 of the lane width
  parameter int NumRounds = 12 + 2 * $clog2(LaneWidth);

  // Counter only has to reach NumRounds-1
  parameter int RoundIdxWidth = $clog2(NumRounds);
  parameter int LaneAddrWidth = $clog2(NumLanes);

  typedef logic [RoundIdxWidth-1:0] round_idx_t;
  typedef logic [LaneAddrWidth-1:0] lane_addr_t;
  typedef logic [DinWidth-1:0]      din_t;

  //////////////////////////////////////////////////
  // Constant tables
  //////////////////////////////////////////////////

  // Iota constants for the full 64-bit lane
  // Narrower lanes use the low LaneWidth bits of each word
  parameter logic [63:0] RoundConst [24] = '{
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808A,
    64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808B,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008A,
    64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009,
    64'h0000_0000_8000_000A,
    64'h0000_0000_8000_808B,
    64'h8000_0000_0000_008B,
    64'h8000_0000_0000_8089,
    64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002,
    64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800A,
    64'h8000_0000_8000_000A,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8008
  };

  // Rho rotation per lane, indexed x + 5*y
  // Applied modulo the lane width in the round logic
  parameter int RhoOffset [NumLanes] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

endpackage

`default_nettype wire
